//--- all.f
hw/dfe_fir_pkg.sv
hw/dfe_stream_pkg.sv
hw/dfe_chan_seq.sv
hw/dfe_intrp_fir.sv
hw/dfe_ovrfl_undfl_det.sv
hw/dfe_fir.sv
tb/tb_dfe_fir.sv

//--- tb/dfe_fir_testdata.txt
# S carrier i q idle_cycles (negative holds clk_en low that long)
# E carrier i q flag_hex of phase 0, then i q flag_hex of phase 1
T impulse_dc
S 0 16384 -16384 0
S 1 4096 4096 0
S 0 0 0 0
S 1 4096 4096 0
S 0 0 0 0
S 1 4096 4096 0
S 0 0 0 0
S 1 4096 4096 0
E 0 -1024 1024 00 -4096 4096 00
E 1 -256 -256 00 -1024 -1024 00
E 0 9216 -9216 00 16383 -16384 00
E 1 2048 2048 00 3071 3071 00
E 0 9216 -9216 00 16383 -16384 00
E 1 4352 4352 00 7167 7167 00
E 0 -1024 1024 00 -4096 4096 00
E 1 4096 4096 00 6143 6143 00
T saturate_gaps
S 0 -32768 32767 0
S 1 0 0 3
S 0 32767 -32768 -4
S 1 0 0 0
S 0 32767 -32768 2
S 1 0 0 -1
S 0 -32768 32767 0
S 1 0 0 0
E 0 2048 -2048 00 8192 -8192 00
E 1 4352 4352 00 7167 7167 00
E 0 -20480 20479 00 -32768 32767 05
E 1 2048 2048 00 3071 3071 00
E 0 -2049 2047 00 -8193 8191 00
E 1 -256 -256 00 -1024 -1024 00
E 0 32767 -32768 05 32767 -32768 0a
E 1 0 0 00 0 0 00
T chan_skip
S 1 0 0 0
S 0 0 0 0
S 1 0 0 0
E 1 0 0 80 0 0 80
E 0 -2049 2047 00 -8193 8191 00
E 1 0 0 00 0 0 00

//--- tb/tb_dfe_fir.sv
`timescale 1ns/1ps

module tb_dfe_fir import dfe_stream_pkg::*; ();

   logic       clk;
   logic       arst_n;
   logic       clk_en;
   beat_t      in_beat;
   logic       in_ready;
   beat_t      out_beat;
   logic [7:0] error_flag;

   string kind_q[$];                  // record order from the data file
   string name_q[$];
   int    s_q[$];                     // four fields per S record
   int    ex_user[$], ex_i[$], ex_q[$], ex_flag[$];  // one entry per output
   int    errors    = 0;
   int    got       = 0;              // outputs seen
   int    exp_total = 0;              // outputs due so far
   int    cycles    = 0;
   int    limit     = 1000000;        // replaced once the file is loaded

   dfe_fir u_dfe_fir (
      .clk        (clk),
      .arst_n     (arst_n),
      .clk_en     (clk_en),
      .in_beat    (in_beat),
      .in_ready   (in_ready),
      .out_beat   (out_beat),
      .error_flag (error_flag)
   );

   always #50 clk = ~clk;  // 100 ns period

   //////////////////////////////////////////////////
   // checks
   task automatic check(string name, int exp_v, int act_v);
      if (exp_v !== act_v) begin
         errors++;
         $display("FAIL %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
      end
   endtask

   // scoreboard, an output counts on an enabled edge only
   always @(posedge clk) begin
      if (arst_n && clk_en && out_beat.valid) begin
         if (ex_user.size() == 0) begin
            errors++;
            $display("unexpected extra output at %0t on carrier %0d", $time, out_beat.user);
         end else begin
            check("out_beat.user", ex_user.pop_front(), int'(out_beat.user));
            check("out_beat.data.i", ex_i.pop_front(), int'($signed(out_beat.data.i)));
            check("out_beat.data.q", ex_q.pop_front(), int'($signed(out_beat.data.q)));
            check("error_flag", ex_flag.pop_front(), int'(error_flag));
         end
         got++;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout after %0d cycles, %0d of %0d outputs seen", cycles, got, exp_total);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // stimulus helpers
   task automatic drive_beat(int ch, int i, int q, int idle);
      in_beat.valid  = 1'b1;
      in_beat.user   = ch[USER_BW-1:0];
      in_beat.data.i = i[PRECISION-1:0];
      in_beat.data.q = q[PRECISION-1:0];
      while (!(in_ready && clk_en)) @(negedge clk);  // data held while stalled
      @(negedge clk);                                 // taken on that edge
      in_beat.valid = 1'b0;
      if (idle < 0) begin
         clk_en = 1'b0;  // freeze
         repeat (-idle) @(negedge clk);
         clk_en = 1'b1;
      end else begin
         repeat (idle) @(negedge clk);
      end
   endtask

   task automatic finish_test(string name, int got_start, int err_start);
      while (got < exp_total) @(negedge clk);  // timeout covers lost outputs
      $display("test %s done, %0d outputs, %0d errors", name, got - got_start,
               errors - err_start);
   endtask

   initial begin
      int    fd, r, a, b, c, d, u, i0, q0, f0, i1, q1, f1;
      int    n_s, idle_sum, got_start, err_start, n_tests;
      string tok, line, nm, cur_name;
      clk = 1'b0;
      arst_n = 1'b0;
      clk_en = 1'b1;
      in_beat = '0;
      n_s = 0;
      idle_sum = 0;
      n_tests = 0;
      cur_name = "";
      got_start = 0;
      err_start = 0;
      fd = $fopen("tb/dfe_fir_testdata.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("cannot open the test data file");
      end else begin
         while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
               r = $fgets(line, fd);           // comment line
            end else if (tok == "T") begin
               r = $fscanf(fd, "%s", nm);
               if (r != 1) begin
                  errors++;
                  $display("test name missing in the test data file");
               end
               name_q.push_back(nm);
               kind_q.push_back(tok);
            end else if (tok == "S") begin
               r = $fscanf(fd, "%d %d %d %d", a, b, c, d);
               if (r != 4) begin
                  errors++;
                  $display("stimulus line with missing fields in the test data file");
               end
               s_q.push_back(a);
               s_q.push_back(b);
               s_q.push_back(c);
               s_q.push_back(d);
               n_s++;
               idle_sum += (d < 0) ? -d : d;
               kind_q.push_back(tok);
            end else if (tok == "E") begin
               r = $fscanf(fd, "%d %d %d %h %d %d %h", u, i0, q0, f0, i1, q1, f1);
               if (r != 7) begin
                  errors++;
                  $display("expected-value line with missing fields in the test data file");
               end
               ex_user.push_back(u);  // phase 0 then phase 1
               ex_i.push_back(i0);
               ex_q.push_back(q0);
               ex_flag.push_back(f0);
               ex_user.push_back(u);
               ex_i.push_back(i1);
               ex_q.push_back(q1);
               ex_flag.push_back(f1);
               kind_q.push_back(tok);
            end
         end
         $fclose(fd);
      end
      limit = 4 * n_s + idle_sum + 100;

      // reset for 2 cycles, outputs must be idle once released
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check("in_ready", 1, int'(in_ready));
      check("out_beat.valid", 0, int'(out_beat.valid));
      check("error_flag", 0, int'(error_flag));
      $display("test reset done, %0d errors", errors);

      foreach (kind_q[k]) begin
         if (kind_q[k] == "T") begin
            if (cur_name != "") finish_test(cur_name, got_start, err_start);
            cur_name = name_q.pop_front();
            got_start = got;
            err_start = errors;
            n_tests++;
         end else if (kind_q[k] == "S") begin
            a = s_q.pop_front();
            b = s_q.pop_front();
            c = s_q.pop_front();
            d = s_q.pop_front();
            drive_beat(a, b, c, d);
         end else begin
            exp_total += 2;  // one E line covers both phases
         end
      end
      if (cur_name != "") finish_test(cur_name, got_start, err_start);
      repeat (10) @(negedge clk);  // room for stray outputs

      $display("tests %0d, outputs %0d, errors %0d", n_tests + 1, got, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

//--- hw/dfe_fir.sv
`timescale 1ns/1ps

module dfe_fir import dfe_stream_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       clk_en,      // low freezes the whole stage
   input  beat_t      in_beat,     // valid field is in_valid
   output logic       in_ready,
   output beat_t      out_beat,    // no ready, consumer always takes it
   output logic [7:0] error_flag
);

   beat_t                       tap_req;
   logic                        tap_phase;
   logic                        seq_chan_err;
   fir_acc_t                    acc;
   logic                        acc_valid;
   logic [USER_BW-1:0]          acc_user;
   logic                        fir_chan_err;
   logic signed [PRECISION-1:0] dout_i;
   logic signed [PRECISION-1:0] dout_q;
   logic                        i_plus1;
   logic                        i_all;
   logic                        q_plus1;
   logic                        q_all;
   logic                        out_valid;   // aligned with saturator outputs
   logic [USER_BW-1:0]          out_user;
   logic                        out_chan_err;

   //////////////////////////////////////////////////
   // input side and filter
   dfe_chan_seq u_dfe_chan_seq (
      .clk       (clk),
      .arst_n    (arst_n),
      .clk_en    (clk_en),
      .in_beat   (in_beat),
      .in_ready  (in_ready),
      .tap_req   (tap_req),
      .tap_phase (tap_phase),
      .chan_err  (seq_chan_err)
   );

   dfe_intrp_fir u_dfe_intrp_fir (
      .clk         (clk),
      .arst_n      (arst_n),
      .clk_en      (clk_en),
      .tap_req     (tap_req),
      .tap_phase   (tap_phase),
      .chan_err_in (seq_chan_err),
      .acc         (acc),
      .acc_valid   (acc_valid),
      .acc_user    (acc_user),
      .chan_err    (fir_chan_err)
   );

   //////////////////////////////////////////////////
   // per rail saturation
   dfe_ovrfl_undfl_det u_i_ovrfl_undfl_det (
      .clk        (clk),
      .arst_n     (arst_n),
      .clk_en     (clk_en),
      .data_in    (acc.i),
      .data_out   (dout_i),
      .flag_plus1 (i_plus1),
      .flag_all   (i_all)
   );

   dfe_ovrfl_undfl_det u_q_ovrfl_undfl_det (
      .clk        (clk),
      .arst_n     (arst_n),
      .clk_en     (clk_en),
      .data_in    (acc.q),
      .data_out   (dout_q),
      .flag_plus1 (q_plus1),
      .flag_all   (q_all)
   );

   // sideband delayed to match the saturator stage
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid    <= 1'b0;
         out_user     <= '0;
         out_chan_err <= 1'b0;
      end else if (clk_en) begin
         out_valid    <= acc_valid;
         out_user     <= acc_user;
         out_chan_err <= fir_chan_err;
      end
   end

   assign out_beat.valid  = out_valid;
   assign out_beat.user   = out_user;
   assign out_beat.data.i = dout_i;   // low half
   assign out_beat.data.q = dout_q;

   // flag byte, bits 6..4 stay zero
   always_comb begin
      error_flag              = '0;
      error_flag[ERR_I_PLUS1] = i_plus1;
      error_flag[ERR_I_ALL]   = i_all;
      error_flag[ERR_Q_PLUS1] = q_plus1;
      error_flag[ERR_Q_ALL]   = q_all;
      error_flag[ERR_CHANID]  = out_chan_err;
   end

endmodule

//--- hw/dfe_ovrfl_undfl_det.sv
`timescale 1ns/1ps

module dfe_ovrfl_undfl_det import dfe_stream_pkg::*, dfe_fir_pkg::*; (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic                        clk_en,
   input  logic signed [FULL_BW-1:0]   data_in,     // one rail, full precision
   output logic signed [PRECISION-1:0] data_out,
   output logic                        flag_plus1,  // needed one extra bit
   output logic                        flag_all     // needed more than that
);

   logic signed [KEPT_BW-1:0]   kept;      // after lsb truncation
   logic                        fit_out;   // fits PRECISION bits
   logic                        fit_one;   // fits PRECISION+1 bits
   logic signed [PRECISION-1:0] sat_val;

   //////////////////////////////////////////////////
   // range check
   assign kept = data_in[FULL_BW-1:DROP_LSBS];  // plain truncation, no rounding

   // bits above the output sign must all copy it
   assign fit_out = (&kept[KEPT_BW-1:PRECISION-1]) || !(|kept[KEPT_BW-1:PRECISION-1]);
   assign fit_one = (&kept[KEPT_BW-1:PRECISION]) || !(|kept[KEPT_BW-1:PRECISION]);

   assign sat_val = kept[KEPT_BW-1] ? SAMPLE_MIN : SAMPLE_MAX;  // clamp by sign

   //////////////////////////////////////////////////
   // registered outputs
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flag_plus1 <= 1'b0;
         flag_all   <= 1'b0;
      end else if (clk_en) begin
         flag_plus1 <= !fit_out && fit_one;
         flag_all   <= !fit_one;
      end
   end

   always_ff @(posedge clk) begin
      if (clk_en) begin
         data_out <= fit_out ? kept[PRECISION-1:0] : sat_val;
      end
   end

endmodule

//--- hw/dfe_intrp_fir.sv
`timescale 1ns/1ps

module dfe_intrp_fir import dfe_stream_pkg::*, dfe_fir_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               clk_en,
   input  beat_t              tap_req,
   input  logic               tap_phase,
   input  logic               chan_err_in,
   output fir_acc_t           acc,        // full precision, both rails
   output logic               acc_valid,
   output logic [USER_BW-1:0] acc_user,
   output logic               chan_err
);

   iq_t                       dly [NUM_CHAN][TAPS_PER_PHASE];  // per carrier, newest at 0
   iq_t                       win [TAPS_PER_PHASE];            // samples into the MAC
   logic [CHAN_BW-1:0]        ch;
   logic                      shift_en;
   logic signed [FULL_BW-1:0] sum_i;
   logic signed [FULL_BW-1:0] sum_q;

   assign ch       = tap_req.user[CHAN_BW-1:0];  // carrier select
   assign shift_en = clk_en && tap_req.valid && !tap_phase;  // only phase 0 loads

   //////////////////////////////////////////////////
   // delay lines
   // cleared on reset so the first outputs of a carrier see zero history
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int c = 0; c < NUM_CHAN; c++) begin
            for (int k = 0; k < TAPS_PER_PHASE; k++) begin
               dly[c][k] <= '0;
            end
         end
      end else if (shift_en) begin
         dly[ch][0] <= tap_req.data;
         for (int k = 1; k < TAPS_PER_PHASE; k++) begin
            dly[ch][k] <= dly[ch][k-1];
         end
      end
   end

   //////////////////////////////////////////////////
   // tap window
   // phase 0 sees the incoming sample ahead of the line,
   // phase 1 sees the line after that shift
   always_comb begin
      if (tap_phase) begin
         for (int k = 0; k < TAPS_PER_PHASE; k++) begin
            win[k] = dly[ch][k];
         end
      end else begin
         win[0] = tap_req.data;   // not yet in the line
         for (int k = 1; k < TAPS_PER_PHASE; k++) begin
            win[k] = dly[ch][k-1];
         end
      end
   end

   //////////////////////////////////////////////////
   // multiply accumulate, all signed at FULL_BW
   always_comb begin
      sum_i = '0;
      sum_q = '0;
      for (int k = 0; k < TAPS_PER_PHASE; k++) begin
         sum_i = sum_i + win[k].i * coef_tab[2*k + tap_phase];  // even or odd tap
         sum_q = sum_q + win[k].q * coef_tab[2*k + tap_phase];
      end
   end

   // result register, id and error ride along
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acc       <= '0;    // keeps saturator flags clean before first beat
         acc_valid <= 1'b0;
         acc_user  <= '0;
         chan_err  <= 1'b0;
      end else if (clk_en) begin
         acc_valid <= tap_req.valid;
         if (tap_req.valid) begin
            acc.i    <= sum_i;
            acc.q    <= sum_q;
            acc_user <= tap_req.user;
            chan_err <= chan_err_in;
         end
      end
   end

   // phase 1 reuses the line phase 0 just loaded, same carrier required
   a_phase_pair : assert property (@(posedge clk iff clk_en) disable iff (!arst_n)
      (tap_req.valid && tap_phase) |->
         ($past(tap_req.valid && !tap_phase) && (tap_req.user == $past(tap_req.user))));

endmodule

//--- hw/dfe_chan_seq.sv
`timescale 1ns/1ps

module dfe_chan_seq import dfe_stream_pkg::*, dfe_fir_pkg::*; (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  clk_en,
   input  beat_t in_beat,    // valid field is the handshake valid
   output logic  in_ready,
   output beat_t tap_req,    // held beat, issued twice
   output logic  tap_phase,  // 0 first issue, 1 second
   output logic  chan_err    // id mismatch, rides both issues
);

   logic               accept;
   logic               req_valid;
   logic [USER_BW-1:0] req_user;
   iq_t                req_data;
   logic [USER_BW-1:0] exp_id;   // id expected on next acceptance
   logic [USER_BW-1:0] next_id;

   // stalled only in the phase 0 slot, next beat can land during phase 1
   assign in_ready = !(req_valid && !tap_phase);
   assign accept   = in_beat.valid && in_ready && clk_en;
   assign next_id  = USER_BW'((int'(in_beat.user) + 1) % NUM_CHAN);  // wraps on NUM_CHAN

   //////////////////////////////////////////////////
   // issue pacing and id check
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         req_valid <= 1'b0;
         tap_phase <= 1'b0;
         chan_err  <= 1'b0;
         exp_id    <= '0;
      end else if (clk_en) begin
         if (accept) begin
            req_valid <= 1'b1;
            tap_phase <= 1'b0;
            chan_err  <= (in_beat.user != exp_id);
            exp_id    <= next_id;       // resync on what was received, one skip one error
         end else if (req_valid && !tap_phase) begin
            tap_phase <= 1'b1;          // second issue of same beat
         end else begin
            req_valid <= 1'b0;          // idle
            tap_phase <= 1'b0;
         end
      end
   end

   // beat held for both issues
   always_ff @(posedge clk) begin
      if (accept) begin
         req_user <= in_beat.user;
         req_data <= in_beat.data;
      end
   end

   assign tap_req.valid = req_valid;
   assign tap_req.user  = req_user;
   assign tap_req.data  = req_data;

   // a beat offered but not taken stays on the bus unchanged
   a_hold_stalled : assert property (@(posedge clk) disable iff (!arst_n)
      (in_beat.valid && !(in_ready && clk_en)) |=> (in_beat.valid && $stable(in_beat)));

endmodule

//--- hw/dfe_stream_pkg.sv
package dfe_stream_pkg;

   import dfe_fir_pkg::*;  // FULL_BW for accumulator words

   //////////////////////////////////////////////////
   // sample and id widths
   localparam int PRECISION = 16;  // I and Q rails
   localparam int USER_BW   = 2;   // carrier id on tuser

   // saturation limits of one rail
   localparam logic signed [PRECISION-1:0] SAMPLE_MAX = {1'b0, {(PRECISION-1){1'b1}}};
   localparam logic signed [PRECISION-1:0] SAMPLE_MIN = {1'b1, {(PRECISION-1){1'b0}}};

   //////////////////////////////////////////////////
   // error_flag bit positions, 6..4 unused
   localparam int ERR_I_PLUS1 = 0;  // I one bit past range
   localparam int ERR_I_ALL   = 1;  // I further out
   localparam int ERR_Q_PLUS1 = 2;
   localparam int ERR_Q_ALL   = 3;
   localparam int ERR_CHANID  = 7;  // carrier id out of sequence

   //////////////////////////////////////////////////
   // stream words
   typedef struct packed {
      logic signed [PRECISION-1:0] q;  // upper half of tdata
      logic signed [PRECISION-1:0] i;  // lower half
   } iq_t;

   typedef struct packed {
      logic               valid;
      logic [USER_BW-1:0] user;  // carrier id
      iq_t                data;
   } beat_t;  // 35 bits

   // full precision filter result per rail
   typedef struct packed {
      logic signed [FULL_BW-1:0] q;
      logic signed [FULL_BW-1:0] i;
   } fir_acc_t;  // 68 bits

endpackage

//--- hw/dfe_fir_pkg.sv
package dfe_fir_pkg;

   //////////////////////////////////////////////////
   // polyphase geometry
   localparam int NUM_CHAN       = 2;                  // carriers sharing the stage
   localparam int CHAN_BW        = $clog2(NUM_CHAN);   // delay line select
   localparam int NUM_TAPS       = 8;
   localparam int TAPS_PER_PHASE = NUM_TAPS / 2;       // interp by 2

   //////////////////////////////////////////////////
   // arithmetic widths
   localparam int COEF_BW   = 16;
   localparam int FULL_BW   = 34;                  // 16x16 product + 2 bits for 4 terms
   localparam int DROP_LSBS = 15;                  // coefs are Q1.15
   localparam int KEPT_BW   = FULL_BW - DROP_LSBS; // 19 bits into the saturator

   //////////////////////////////////////////////////
   // prototype filter, index is tap number
   // phase 0 takes the even taps, phase 1 the odd ones
   // even taps sum to exactly 1.0, so full scale DC just fits
   // odd taps sum to about 1.5, full scale DC lands one bit over
   // sign matched full scale on the odd phase goes past 2.0
   localparam logic signed [COEF_BW-1:0] coef_tab [NUM_TAPS] = '{
      -16'sd2048,   // tap 0, phase 0
      -16'sd8192,   // tap 1, phase 1
      16'sd18432,   // tap 2
      16'sd32767,   // tap 3
      16'sd18432,   // tap 4
      16'sd32767,   // tap 5
      -16'sd2048,   // tap 6
      -16'sd8192    // tap 7
   };

   // delay line k of a phase meets coef_tab[2*k + phase]
   // k = 0 is the newest sample of that carrier
   // so the phase output is y = sum x[n-k] * c[2k+p] >> 15

endpackage
